/* hdl/sched_cfg.svh */
// register-bank engine configuration
`ifndef SCHED_CFG_SVH
`define SCHED_CFG_SVH

// channel number width, 1 << bits requesters
`define SCHED_CHN_BITS 2

// bank address width, 1 << bits words
`define SCHED_ADDR_W 4

// data word width
`define SCHED_DATA_W 16

`endif

/* hdl/sched_pkg.sv */
// register-bank engine types
`include "sched_cfg.svh"

package sched_pkg;

    typedef logic [`SCHED_CHN_BITS-1:0]      chn_t;     // channel number
    typedef logic [(1<<`SCHED_CHN_BITS)-1:0] chn_vec_t; // one bit per channel
    typedef logic [`SCHED_ADDR_W-1:0]        addr_t;    // bank word address
    typedef logic [`SCHED_DATA_W-1:0]        data_t;    // bank data word

    // command opcodes
    typedef logic [1:0] op_t;

    localparam op_t OP_READ  = 2'd0; // return stored word
    localparam op_t OP_WRITE = 2'd1; // store data, return it
    localparam op_t OP_ADD   = 2'd2; // store sum, return sum
    localparam op_t OP_XCHG  = 2'd3; // store data, return old word

    // result stage FSM
    typedef enum logic {
        IDLE, // arbitration enabled
        BUSY  // one command in flight
    } res_state_t;

endpackage

/* hdl/sched_if.sv */
// command and response channels

// decode -> execute
interface cmd_if import sched_pkg::*; ();

    logic  valid; // one-cycle pulse
    chn_t  chn;   // owner of the command
    op_t   op;
    addr_t addr;
    data_t data;

    modport src (output valid, output chn, output op, output addr, output data);
    modport dst (input  valid, input  chn, input  op, input  addr, input  data);

endinterface

// execute -> result
interface rsp_if import sched_pkg::*; ();

    logic  valid; // one-cycle pulse
    chn_t  chn;   // channel to answer
    data_t rdata; // returned word

    modport src (output valid, output chn, output rdata);
    modport dst (input  valid, input  chn, input  rdata);

endinterface

/* hdl/round_robin.sv */
// request arbiter, round-robin or fixed priority
module round_robin import sched_pkg::*; #(
    parameter int FIXED_PRIORITY = 0    // 0 round-robin, 1 channel 0 always first
) (
    input  logic     clk,
    input  logic     srst,
    input  chn_vec_t rq,                // request levels
    input  logic     en,                // arbitration enable, must drop after a grant
    output logic     grant,             // one-cycle pulse
    output chn_t     chn,               // last granted channel
    output chn_vec_t grant_chn          // one-hot grant pulse
);

    localparam int NCH = $bits(chn_vec_t);

    chn_t last_chn;                     // last served, lowest priority next time
    chn_t search_from;
    chn_t next_chn;
    logic any_rq;
    logic armed_r;                      // grant issued, waiting for en low
    logic pre_grant;

    // search starts one past this channel
    function automatic logic [$bits(chn_t):0] pick_next(chn_vec_t req, chn_t from);
        logic found;
        chn_t idx;
        chn_t win;
        found = 1'b0;
        win   = from;
        for (int i = 1; i <= NCH; i++) begin
            idx = chn_t'(from + i);     // wraps modulo channel count
            if (!found && req[idx]) begin
                found = 1'b1;
                win   = idx;
            end
        end
        return {found, win};
    endfunction

    assign search_from        = (FIXED_PRIORITY != 0) ? chn_t'(NCH - 1) : last_chn;
    assign {any_rq, next_chn} = pick_next(rq, search_from);
    assign pre_grant          = en && any_rq && !armed_r;
    assign chn                = last_chn;

    always_ff @(posedge clk) begin
        if (srst) begin
            last_chn  <= chn_t'(NCH - 1); // channel 0 wins first
            armed_r   <= 1'b0;
            grant     <= 1'b0;
            grant_chn <= '0;
        end else begin
            if (pre_grant)
                last_chn <= next_chn;
            if (!en)
                armed_r <= 1'b0;        // re-arm once en has been low
            else if (any_rq)
                armed_r <= 1'b1;
            grant     <= pre_grant;
            grant_chn <= pre_grant ? chn_vec_t'(1) << next_chn : '0;
        end
    end

endmodule

/* hdl/cmd_decode.sv */
// command latch for the granted channel
module cmd_decode import sched_pkg::*; (
    input  logic clk,
    input  logic srst,
    input  logic grant,                 // arbiter pulse
    input  chn_t chn,                   // winner, valid with grant
    input  logic [$bits(chn_vec_t)*$bits(op_t)-1:0]   cmd_op,
    input  logic [$bits(chn_vec_t)*$bits(addr_t)-1:0] cmd_addr,
    input  logic [$bits(chn_vec_t)*$bits(data_t)-1:0] cmd_data,
    cmd_if.src   cmd
);

    localparam int OP_W   = $bits(op_t);
    localparam int ADDR_W = $bits(addr_t);
    localparam int DATA_W = $bits(data_t);

    op_t   op_sel;
    addr_t addr_sel;
    data_t data_sel;

    // slice out the winner's fields
    assign op_sel   = cmd_op[chn*OP_W +: OP_W];
    assign addr_sel = cmd_addr[chn*ADDR_W +: ADDR_W];
    assign data_sel = cmd_data[chn*DATA_W +: DATA_W];

    always_ff @(posedge clk) begin
        if (srst)
            cmd.valid <= 1'b0;
        else
            cmd.valid <= grant;         // one cycle behind the grant
    end

    // payload, held until the next grant
    always_ff @(posedge clk) begin
        if (grant) begin
            cmd.chn  <= chn;
            cmd.op   <= op_sel;
            cmd.addr <= addr_sel;
            cmd.data <= data_sel;
        end
    end

endmodule

/* hdl/bank_execute.sv */
// register bank with read, write, add and exchange
module bank_execute import sched_pkg::*; (
    input  logic clk,
    input  logic srst,
    cmd_if.dst   cmd,
    rsp_if.src   rsp
);

    localparam int DEPTH = 1 << $bits(addr_t);

    data_t bank [DEPTH];
    data_t old_word;                    // current contents at cmd.addr
    data_t new_word;                    // value written back
    data_t ret_word;                    // value returned to the channel
    logic  wr_en;

    assign old_word = bank[cmd.addr];

    always_comb begin
        new_word = old_word;
        ret_word = old_word;
        wr_en    = 1'b0;
        unique case (cmd.op)
            OP_READ: ;                  // no change to the bank
            OP_WRITE: begin
                new_word = cmd.data;
                ret_word = cmd.data;
                wr_en    = 1'b1;
            end
            OP_ADD: begin
                new_word = old_word + cmd.data; // wraps to data width
                ret_word = old_word + cmd.data;
                wr_en    = 1'b1;
            end
            OP_XCHG: begin
                new_word = cmd.data;    // old word goes back
                wr_en    = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (srst) begin
            for (int i = 0; i < DEPTH; i++)
                bank[i] <= '0;
            rsp.valid <= 1'b0;
        end else begin
            if (cmd.valid && wr_en)
                bank[cmd.addr] <= new_word;
            rsp.valid <= cmd.valid;     // exactly one cycle later
        end
    end

    always_ff @(posedge clk) begin
        if (cmd.valid) begin
            rsp.chn   <= cmd.chn;
            rsp.rdata <= ret_word;
        end
    end

endmodule

/* hdl/result_route.sv */
// response demux and engine busy tracking
module result_route import sched_pkg::*; (
    input  logic     clk,
    input  logic     srst,
    input  logic     grant,             // command accepted by the arbiter
    rsp_if.dst       rsp,
    output chn_vec_t done,              // one-hot pulse to the owner
    output data_t    rdata,             // valid with done
    output logic     idle               // arbiter enable
);

    res_state_t state;
    res_state_t state_nxt;

    always_comb begin
        state_nxt = state;
        unique case (state)
            IDLE: if (grant)     state_nxt = BUSY;
            BUSY: if (rsp.valid) state_nxt = IDLE; // idle again while done is out
        endcase
    end

    assign idle = (state == IDLE);

    always_ff @(posedge clk) begin
        if (srst) begin
            state <= IDLE;
            done  <= '0;
        end else begin
            state <= state_nxt;
            done  <= rsp.valid ? chn_vec_t'(1) << rsp.chn : '0;
        end
    end

    // data word rides alongside done
    always_ff @(posedge clk) begin
        if (rsp.valid)
            rdata <= rsp.rdata;
    end

endmodule

/* hdl/sched_top.sv */
// four-channel register-bank access engine
module sched_top import sched_pkg::*; #(
    parameter int FIXED_PRIORITY = 0    // arbiter mode
) (
    input  logic     clk,
    input  logic     srst,
    input  chn_vec_t req,               // request levels, one per channel
    input  logic [$bits(chn_vec_t)*$bits(op_t)-1:0]   cmd_op,
    input  logic [$bits(chn_vec_t)*$bits(addr_t)-1:0] cmd_addr,
    input  logic [$bits(chn_vec_t)*$bits(data_t)-1:0] cmd_data,
    output chn_vec_t done,              // one-hot completion pulse
    output data_t    rdata              // result, valid with done
);

    logic grant;
    chn_t grant_chn_num;
    logic idle;

    cmd_if i_cmd ();
    rsp_if i_rsp ();

    round_robin #(
        .FIXED_PRIORITY (FIXED_PRIORITY)
    ) i_round_robin (
        .clk       (clk),
        .srst      (srst),
        .rq        (req),
        .en        (idle),              // held low while a command is in flight
        .grant     (grant),
        .chn       (grant_chn_num),
        .grant_chn ()                   // one-hot form not needed here
    );

    cmd_decode i_cmd_decode (
        .clk      (clk),
        .srst     (srst),
        .grant    (grant),
        .chn      (grant_chn_num),
        .cmd_op   (cmd_op),
        .cmd_addr (cmd_addr),
        .cmd_data (cmd_data),
        .cmd      (i_cmd.src)
    );

    bank_execute i_bank_execute (
        .clk  (clk),
        .srst (srst),
        .cmd  (i_cmd.dst),
        .rsp  (i_rsp.src)
    );

    result_route i_result_route (
        .clk   (clk),
        .srst  (srst),
        .grant (grant),
        .rsp   (i_rsp.dst),
        .done  (done),
        .rdata (rdata),
        .idle  (idle)
    );

endmodule

/* verif/tb_sched.sv */
// register-bank engine testbench
module tb_sched import sched_pkg::*; ();

    localparam int NCH          = 4;
    localparam int RESET_CYCLES = 10;
    localparam int N_RAND       = 200;
    localparam int N_CMDS       = 12 + 2 + 4 + N_RAND;   // fairness, write/read, add/xchg, random
    localparam int WATCHDOG     = N_CMDS * 8 + 200 + RESET_CYCLES;
    localparam int LATENCY      = 4;                     // request edge to done

    logic        clk = 1'b0;
    logic        srst;
    chn_vec_t    req;
    logic [7:0]  cmd_op;
    logic [15:0] cmd_addr;
    logic [63:0] cmd_data;
    chn_vec_t    done;
    data_t       rdata;

    int    seed = 32'h79d4;
    int    err_val = 0;                  // value mismatches
    int    err_other = 0;                // protocol failures
    int    n_done = 0;
    int    cyc = 0;                      // rising edges seen
    data_t ref_bank [16];                // model of the register bank
    int    last_chn;                     // model arbiter state
    int    busy_left;                    // edges until the engine takes a new request

    op_t   q_op   [NCH][256];            // per-channel command lists
    addr_t q_addr [NCH][256];
    data_t q_data [NCH][256];
    int    q_gap  [NCH][256];
    int    q_len  [NCH];

    int    exp_chn[$];                   // granted commands in order
    op_t   exp_op[$];
    addr_t exp_addr[$];
    data_t exp_data[$];
    int    exp_cyc[$];                   // edge that sampled the request
    int    done_log[$];                  // observed channel per done
    data_t rdata_log[$];

    sched_top #(.FIXED_PRIORITY(0)) i_sched_top (
        .clk(clk), .srst(srst), .req(req), .cmd_op(cmd_op), .cmd_addr(cmd_addr),
        .cmd_data(cmd_data), .done(done), .rdata(rdata)
    );

    always #5 clk = ~clk;

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            err_val++;
            $display("error: %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    // returns the expected word and updates the model bank
    function automatic data_t ref_exec(input op_t op, input addr_t addr, input data_t data);
        data_t old;
        old = ref_bank[addr];
        case (op)
            OP_READ: return old;
            OP_WRITE: begin
                ref_bank[addr] = data;
                return data;
            end
            OP_ADD: begin
                ref_bank[addr] = old + data;
                return old + data;
            end
            default: begin                       // exchange
                ref_bank[addr] = data;
                return old;
            end
        endcase
    endfunction

    // first requester after the last served one
    function automatic int ref_next_chn(input int last, input chn_vec_t rq);
        int idx;
        for (int i = 1; i <= NCH; i++) begin
            idx = (last + i) % NCH;
            if (rq[idx]) return idx;
        end
        return last;
    endfunction

    function automatic int chn_of_done(input chn_vec_t d);
        for (int i = 0; i < NCH; i++)
            if (d[i]) return i;
        return -1;
    endfunction

    task automatic add_cmd(input int c, input op_t op, input addr_t a, input data_t d,
                           input int gap);
        q_op[c][q_len[c]]   = op;
        q_addr[c][q_len[c]] = a;
        q_data[c][q_len[c]] = d;
        q_gap[c][q_len[c]]  = gap;
        q_len[c]++;
    endtask

    // one requester holds req and command until its done bit
    task automatic run_requester(input int c);
        for (int k = 0; k < q_len[c]; k++) begin
            repeat (q_gap[c][k] + 1) @(negedge clk);
            cmd_op[c*2 +: 2]    = q_op[c][k];
            cmd_addr[c*4 +: 4]  = q_addr[c][k];
            cmd_data[c*16 +: 16] = q_data[c][k];
            req[c] = 1'b1;
            do @(negedge clk); while (!done[c]);
            req[c] = 1'b0;                       // dropped before the next edge
        end
    endtask

    task automatic run_all();
        fork
            run_requester(0);
            run_requester(1);
            run_requester(2);
            run_requester(3);
        join
        @(negedge clk);                          // let the last compare settle
        for (int c = 0; c < NCH; c++)
            q_len[c] = 0;
    endtask

    // predicts the winner at each granting edge
    always @(posedge clk) begin : arb_model
        int c;
        cyc = cyc + 1;
        if (srst) begin
            busy_left = 0;
            last_chn  = NCH - 1;                // channel 0 first
        end else begin
            if (busy_left > 0)
                busy_left = busy_left - 1;
            if (busy_left == 0 && req != '0) begin
                c = ref_next_chn(last_chn, req);
                last_chn = c;
                exp_chn.push_back(c);
                exp_op.push_back(cmd_op[c*2 +: 2]);
                exp_addr.push_back(cmd_addr[c*4 +: 4]);
                exp_data.push_back(cmd_data[c*16 +: 16]);
                exp_cyc.push_back(cyc);
                busy_left = LATENCY;            // free again at the edge ending done
            end
        end
    end

    always @(negedge clk) begin : compare
        int c;
        if (!srst && done != '0) begin
            n_done++;
            check_val("done_count", $countones(done), 1);
            done_log.push_back(chn_of_done(done));
            rdata_log.push_back(rdata);
            if (exp_chn.size() == 0) begin
                err_other++;
                $display("done pulse seen with no command outstanding");
            end else begin
                c = exp_chn.pop_front();
                check_val("done", done, 32'(1) << c);
                check_val("latency", cyc + 1 - exp_cyc.pop_front(), LATENCY);   // sampled at 4th edge
                check_val("rdata", rdata,
                          ref_exec(exp_op.pop_front(), exp_addr.pop_front(), exp_data.pop_front()));
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG) @(posedge clk);
        $display("timed out after %0d cycles waiting for done pulses", WATCHDOG);
        $display("** FAIL **");
        $finish;
    end

    initial begin : main
        int c;
        srst = 1'b1;
        req = '0;
        cmd_op = '0;
        cmd_addr = '0;
        cmd_data = '0;
        for (int i = 0; i < 16; i++)
            ref_bank[i] = '0;
        for (int i = 0; i < NCH; i++)
            q_len[i] = 0;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_val("done", done, 0);
        end
        srst = 1'b0;
        @(negedge clk);
        check_val("done", done, 0);             // quiet in the first cycle too

        // all channels busy and served in strict rotation
        for (int k = 0; k < 3; k++)
            for (int i = 0; i < NCH; i++)
                add_cmd(i, OP_WRITE, addr_t'(i * 4 + k), data_t'(16'h1000 * i + k), 0);
        run_all();
        for (int i = 0; i < done_log.size(); i++)
            check_val("fair_chn", done_log[i], i % NCH);

        rdata_log.delete();                     // single channel write then read back
        add_cmd(1, OP_WRITE, 4'd5, 16'h1234, 0);
        add_cmd(1, OP_READ, 4'd5, 16'h0000, 2);
        run_all();
        check_val("read_back", rdata_log[1], 16'h1234);

        rdata_log.delete();                     // add wraps and exchange returns the old word
        add_cmd(2, OP_WRITE, 4'd9, 16'hfff0, 0);
        add_cmd(2, OP_ADD, 4'd9, 16'h0025, 1);
        add_cmd(2, OP_XCHG, 4'd9, 16'hbeef, 0);
        add_cmd(2, OP_READ, 4'd9, 16'h0000, 3);
        run_all();
        check_val("add_sum", rdata_log[1], 16'h0015);
        check_val("xchg_old", rdata_log[2], 16'h0015);
        check_val("xchg_new", rdata_log[3], 16'hbeef);

        for (int n = 0; n < N_RAND; n++) begin   // random mix with gaps
            c = {$random(seed)} % NCH;
            add_cmd(c, op_t'({$random(seed)} % 4), addr_t'($random(seed)),
                    data_t'($random(seed)), {$random(seed)} % 4);
        end
        run_all();

        check_val("commands_done", n_done, N_CMDS);
        if (exp_chn.size() != 0) begin
            err_other++;
            $display("%0d granted commands never completed", exp_chn.size());
        end
        $display("errors: %0d value mismatches, %0d other failures", err_val, err_other);
        if (err_val + err_other == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

/* project.f */
+incdir+hdl
hdl/sched_pkg.sv
hdl/sched_if.sv
hdl/round_robin.sv
hdl/cmd_decode.sv
hdl/bank_execute.sv
hdl/result_route.sv
hdl/sched_top.sv
verif/tb_sched.sv

/* Makefile */
# Verilator flow for the register-bank engine

VERILATOR ?= verilator
FLIST     ?= project.f
TB_TOP    ?= tb_sched
DUT_TOP   ?= sched_top
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
LINT_OPTS ?= --lint-only -Wall

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_OPTS) $(VFLAGS) -f $(FLIST) --top-module $(DUT_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -qx '\*\* PASS \*\*' $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
